//--- opl_lite.f
+incdir+.
opl_lite_pkg.sv
opl_ctrl_if.sv
opl_host_regs.sv
opl_tone_channels.sv
opl_timers.sv
opl_output_mix.sv
opl_lite.sv
tb_clock.sv
tb_opl_lite.sv

//--- run.sh
#!/bin/sh
# build and run the opl lite testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_opl_lite \
    -f opl_lite.f -o tb_opl_lite > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_opl_lite > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tb_opl_lite.sv
/*
 * opl lite testbench
 * host bus stimulus, shadow tone model and assertion based checks
 */
`include "opl_lite_macros.svh"

module tb_opl_lite;

    localparam int SAMPLE_TIMEOUT = 4 * `OPL_CLK_DIV_COUNT;      // cycles to the next sample
    localparam int PHASE_W        = `OPL_PHASE_WIDTH;

    logic                    clk;
    logic                    reset;
    logic                    cs_n;
    logic                    rd_n;
    logic                    wr_n;
    logic [1:0]              address;
    opl_lite_pkg::reg_data_t din;
    opl_lite_pkg::reg_data_t dout;
    logic                    sample_valid;
    opl_lite_pkg::mix_t      sample_l;
    opl_lite_pkg::mix_t      sample_r;
    logic                    irq_n;

    logic [31:0]             lfsr_state = 32'h6282;
    int                      mismatch_count = 0;
    int                      timeout_count = 0;
    logic                    irq_quiet;                          // irq_n must stay high
    opl_lite_pkg::reg_data_t exp_dout;                           // expected status readback
    opl_lite_pkg::mix_t      exp_l;
    opl_lite_pkg::mix_t      exp_r;
    logic [PHASE_W-1:0]      model_phase [`OPL_NUM_CHANNELS];    // shadow accumulators
    opl_lite_pkg::fnum_t     model_fnum  [`OPL_NUM_CHANNELS];
    logic [`OPL_NUM_CHANNELS-1:0] model_kon;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    opl_lite u_opl_lite (
        .clk          (clk),
        .reset        (reset),
        .cs_n         (cs_n),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .address      (address),
        .din          (din),
        .dout         (dout),
        .sample_valid (sample_valid),
        .sample_l     (sample_l),
        .sample_r     (sample_r),
        .irq_n        (irq_n)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);                  // one step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int channel_level(input int ch);
        if (!model_kon[ch])
            return 0;                                            // keyed off is silent
        return model_phase[ch][PHASE_W-1] ? -`OPL_AMPLITUDE : `OPL_AMPLITUDE;
    endfunction

    // shadow model, advanced once per output sample
    always @(negedge clk) begin
        if (reset) begin
            for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++)
                model_phase[ch] = '0;
            exp_l = '0;
            exp_r = '0;
        end else if (sample_valid) begin
            for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++) begin
                if (model_kon[ch])
                    model_phase[ch] = model_phase[ch] + PHASE_W'(model_fnum[ch]);
                else
                    model_phase[ch] = '0;
            end
            exp_l = opl_lite_pkg::mix_t'(channel_level(0) + channel_level(2));  // a + c
            exp_r = opl_lite_pkg::mix_t'(channel_level(1) + channel_level(3));  // b + d
        end
    end

    a_left_sum: assert property (@(posedge clk) disable iff (reset)
        sample_valid |-> sample_l == exp_l)
    else begin
        mismatch_count++;
        $display("Mismatch t=%0t sample_l got %0d expected %0d",
                 $time, $sampled(sample_l), $sampled(exp_l));
    end

    a_right_sum: assert property (@(posedge clk) disable iff (reset)
        sample_valid |-> sample_r == exp_r)
    else begin
        mismatch_count++;
        $display("Mismatch t=%0t sample_r got %0d expected %0d",
                 $time, $sampled(sample_r), $sampled(exp_r));
    end

    a_status_read: assert property (@(posedge clk) disable iff (reset)
        (!cs_n && !rd_n && address == 2'd0) |=> dout == exp_dout)
    else begin
        mismatch_count++;
        $display("Mismatch t=%0t dout got %02h expected %02h",
                 $time, $sampled(dout), $sampled(exp_dout));
    end

    a_irq_quiet: assert property (@(posedge clk) disable iff (reset)
        irq_quiet |-> irq_n)
    else begin
        mismatch_count++;
        $display("Mismatch t=%0t irq_n got %0b expected 1", $time, $sampled(irq_n));
    end

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < 64) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (reset) begin
            timeout_count++;
            $display("Timeout at %0t: reset was never released", $time);
        end
    endtask

    task automatic wait_sample();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!sample_valid && cycles < SAMPLE_TIMEOUT);
        if (!sample_valid) begin
            timeout_count++;
            $display("Timeout at %0t: no sample_valid pulse arrived", $time);
        end
    endtask

    task automatic wait_samples(input int n);
        repeat (n) wait_sample();
    endtask

    task automatic wait_irq(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (irq_n != level && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (irq_n != level) begin
            timeout_count++;
            $display("Timeout at %0t: %s", $time, what);
        end
    endtask

    // index then data write, placed just after a sample so the next tick sees both
    task automatic reg_write(input opl_lite_pkg::reg_index_t index,
                             input opl_lite_pkg::reg_data_t data);
        int ch;
        wait_sample();
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        address = 2'd0;
        din     = index;
        @(posedge clk);
        #1;
        address = 2'd1;
        din     = data;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
        ch   = int'(index[3:0]);
        if (ch < `OPL_NUM_CHANNELS && (index & 8'hF0) == opl_lite_pkg::REG_FNUM_LO)
            model_fnum[ch][7:0] = data;
        if (ch < `OPL_NUM_CHANNELS && (index & 8'hF0) == opl_lite_pkg::REG_KON_FNUM) begin
            model_kon[ch]       = data[opl_lite_pkg::KON_BIT];
            model_fnum[ch][9:8] = data[1:0];
        end
    endtask

    task automatic key_channel(input int ch, input opl_lite_pkg::fnum_t fnum, input logic on);
        reg_write(opl_lite_pkg::REG_FNUM_LO | 8'(ch), fnum[7:0]);
        reg_write(opl_lite_pkg::REG_KON_FNUM | 8'(ch), {2'b00, on, 3'b000, fnum[9:8]});
    endtask

    task automatic status_read(input opl_lite_pkg::reg_data_t expected);
        exp_dout = expected;
        cs_n     = 1'b0;
        rd_n     = 1'b0;
        address  = 2'd0;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        rd_n = 1'b1;
        @(posedge clk);                                          // dout checked here
        #1;
    endtask

    initial begin
        int                   bound;
        opl_lite_pkg::timer_t preset;
        cs_n      = 1'b1;
        rd_n      = 1'b1;
        wr_n      = 1'b1;
        address   = 2'd0;
        din       = '0;
        irq_quiet = 1'b1;
        exp_dout  = '0;
        model_kon = '0;
        for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++)
            model_fnum[ch] = '0;
        wait_reset_release();

        wait_samples(8);                                         // silent after reset
        status_read(8'h00);

        key_channel(0, 10'h200 | 10'(random_bits(9)), 1'b1);    // channel a alone
        wait_samples(64);

        for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++)
            key_channel(ch, 10'h200 | 10'(random_bits(9)), 1'b1);
        wait_samples(64);
        key_channel(2, model_fnum[2], 1'b0);                     // c drops out of the left sum
        wait_samples(16);
        for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++)
            key_channel(ch, model_fnum[ch], 1'b0);
        wait_samples(4);

        // timer 1 overflow
        preset = 8'hC0 | 8'(random_bits(6));
        reg_write(opl_lite_pkg::REG_TIMER1, preset);
        irq_quiet = 1'b0;
        reg_write(opl_lite_pkg::REG_TIMER_CTRL, 8'h01);          // st1
        bound = (256 - int'(preset)) * `OPL_TIMER1_DIV * `OPL_CLK_DIV_COUNT + 64;
        wait_irq(1'b0, bound, "timer 1 interrupt never arrived");
        status_read(8'hC0);                                      // irq and ft1

        // stop, then flag reset
        reg_write(opl_lite_pkg::REG_TIMER_CTRL, 8'h00);
        reg_write(opl_lite_pkg::REG_TIMER_CTRL, 8'h80);          // irq_rst only
        wait_irq(1'b1, 16, "irq_n stayed low after the flag reset");
        irq_quiet = 1'b1;
        status_read(8'h00);

        // masked timer 2 over two full periods
        preset = 8'hC0 | 8'(random_bits(6));
        reg_write(opl_lite_pkg::REG_TIMER2, preset);
        reg_write(opl_lite_pkg::REG_TIMER_CTRL, 8'h22);          // mt2 and st2
        repeat (2 * (256 - int'(preset)) * `OPL_TIMER2_DIV * `OPL_CLK_DIV_COUNT) @(posedge clk);
        #1;
        status_read(8'h00);
        reg_write(opl_lite_pkg::REG_TIMER_CTRL, 8'h00);

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb_clock.sv
/*
 * testbench clock and reset
 * free running clk and a synchronous reset held for a fixed number of cycles
 */
module tb_clock #(
    parameter int HALF_PERIOD  = 2,                              // period of 4
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;                                            // released just after an edge
    end

endmodule

//--- opl_lite.sv
/*
 * opl lite top level
 * host port, tone channels, timers and output mixer
 */
module opl_lite (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cs_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic [1:0]              address,
    input  opl_lite_pkg::reg_data_t din,
    output opl_lite_pkg::reg_data_t dout,
    output logic                    sample_valid,
    output opl_lite_pkg::mix_t      sample_l,
    output opl_lite_pkg::mix_t      sample_r,
    output logic                    irq_n
);

    logic                  sample_tick;
    logic                  channel_valid;
    opl_lite_pkg::sample_t channel_a;
    opl_lite_pkg::sample_t channel_b;
    opl_lite_pkg::sample_t channel_c;
    opl_lite_pkg::sample_t channel_d;
    logic                  ft1;
    logic                  ft2;
    opl_lite_pkg::status_t status;                               // mixer back to the host port

    opl_ctrl_if ctrl ();

    opl_host_regs u_host_regs (
        .clk     (clk),
        .reset   (reset),
        .cs_n    (cs_n),
        .rd_n    (rd_n),
        .wr_n    (wr_n),
        .address (address),
        .din     (din),
        .dout    (dout),
        .status  (status),
        .ctrl    (ctrl.regs)
    );

    opl_tone_channels u_tone_channels (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl.tone),
        .sample_tick   (sample_tick),
        .channel_valid (channel_valid),
        .channel_a     (channel_a),
        .channel_b     (channel_b),
        .channel_c     (channel_c),
        .channel_d     (channel_d)
    );

    opl_timers u_timers (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .ctrl        (ctrl.timers),
        .ft1         (ft1),
        .ft2         (ft2)
    );

    opl_output_mix u_output_mix (
        .clk           (clk),
        .reset         (reset),
        .channel_valid (channel_valid),
        .channel_a     (channel_a),
        .channel_b     (channel_b),
        .channel_c     (channel_c),
        .channel_d     (channel_d),
        .ft1           (ft1),
        .ft2           (ft2),
        .sample_valid  (sample_valid),
        .sample_l      (sample_l),
        .sample_r      (sample_r),
        .status        (status),
        .irq_n         (irq_n)
    );

endmodule

//--- opl_output_mix.sv
/*
 * opl lite output mixer
 * left and right sums, sample strobe, status byte and interrupt
 */
module opl_output_mix (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  channel_valid,
    input  opl_lite_pkg::sample_t channel_a,
    input  opl_lite_pkg::sample_t channel_b,
    input  opl_lite_pkg::sample_t channel_c,
    input  opl_lite_pkg::sample_t channel_d,
    input  logic                  ft1,
    input  logic                  ft2,
    output logic                  sample_valid,
    output opl_lite_pkg::mix_t    sample_l,
    output opl_lite_pkg::mix_t    sample_r,
    output opl_lite_pkg::status_t status,
    output logic                  irq_n
);

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_valid <= 1'b0;
            sample_l     <= '0;
            sample_r     <= '0;
            status       <= '0;
        end else begin
            sample_valid <= channel_valid;                       // one clk behind the channels
            if (channel_valid) begin
                sample_l <= opl_lite_pkg::mix_t'(channel_a) + opl_lite_pkg::mix_t'(channel_c);
                sample_r <= opl_lite_pkg::mix_t'(channel_b) + opl_lite_pkg::mix_t'(channel_d);
            end
            status.irq  <= ft1 || ft2;
            status.ft1  <= ft1;
            status.ft2  <= ft2;
            status.zero <= '0;
        end
    end

    assign irq_n = !status.irq;                                  // active low pin

    a_irq_follows_flags: assert property (@(posedge clk) disable iff (reset)
        {!irq_n, status.irq} == {2{status.ft1 || status.ft2}});

endmodule

//--- opl_timers.sv
/*
 * opl lite interval timers
 * two prescaled up counters with reload, start, mask and flag clear
 */
`include "opl_lite_macros.svh"

module opl_timers (
    input  logic        clk,
    input  logic        reset,
    input  logic        sample_tick,
    opl_ctrl_if.timers  ctrl,
    output logic        ft1,
    output logic        ft2
);

    localparam int PRE_W = $clog2(`OPL_TIMER2_DIV);              // wide enough for both
    localparam int PRE_DIV [2] = '{`OPL_TIMER1_DIV, `OPL_TIMER2_DIV};

    opl_lite_pkg::timer_t preset  [2];
    opl_lite_pkg::timer_t count   [2];
    logic [PRE_W-1:0]     pre_cnt [2];                           // sample ticks in a step
    logic                 start   [2];
    logic                 start_q [2];                           // for start edge
    logic                 mask    [2];
    logic                 flag    [2];

    assign preset[0] = ctrl.timer1;
    assign preset[1] = ctrl.timer2;
    assign start[0]  = ctrl.st1;
    assign start[1]  = ctrl.st2;
    assign mask[0]   = ctrl.mt1;
    assign mask[1]   = ctrl.mt2;

    for (genvar t = 0; t < 2; t++) begin : g_timer
        always_ff @(posedge clk) begin
            if (reset) begin
                count[t]   <= '0;
                pre_cnt[t] <= '0;
                start_q[t] <= 1'b0;
                flag[t]    <= 1'b0;
            end else begin
                start_q[t] <= start[t];
                if (start[t] && !start_q[t]) begin
                    count[t]   <= preset[t];                     // fresh start
                    pre_cnt[t] <= '0;
                end else if (start[t] && sample_tick) begin
                    if (pre_cnt[t] == PRE_W'(PRE_DIV[t] - 1)) begin
                        pre_cnt[t] <= '0;
                        if (count[t] == 8'hFF) begin
                            count[t] <= preset[t];               // overflow reloads
                            if (!mask[t])
                                flag[t] <= 1'b1;
                        end else begin
                            count[t] <= count[t] + 1'b1;
                        end
                    end else begin
                        pre_cnt[t] <= pre_cnt[t] + 1'b1;
                    end
                end
                if (ctrl.irq_rst)
                    flag[t] <= 1'b0;                             // clear wins over set
            end
        end

        a_mask_holds_flag: assert property (@(posedge clk) disable iff (reset)
            $rose(flag[t]) |-> !$past(mask[t]) && $past(start[t]));
    end

    assign ft1 = flag[0];
    assign ft2 = flag[1];

endmodule

//--- opl_tone_channels.sv
/*
 * opl lite tone channels
 * sample rate divider and four square wave phase accumulators
 */
`include "opl_lite_macros.svh"

module opl_tone_channels (
    input  logic                  clk,
    input  logic                  reset,
    opl_ctrl_if.tone              ctrl,
    output logic                  sample_tick,
    output logic                  channel_valid,
    output opl_lite_pkg::sample_t channel_a,
    output opl_lite_pkg::sample_t channel_b,
    output opl_lite_pkg::sample_t channel_c,
    output opl_lite_pkg::sample_t channel_d
);

    localparam int DIV_W   = $clog2(`OPL_CLK_DIV_COUNT);
    localparam int PHASE_W = `OPL_PHASE_WIDTH;
    localparam opl_lite_pkg::sample_t AMP = opl_lite_pkg::sample_t'(`OPL_AMPLITUDE);

    logic [DIV_W-1:0]      div_cnt;                              // clk cycles in this tick
    logic [PHASE_W-1:0]    phase      [`OPL_NUM_CHANNELS];
    logic [PHASE_W-1:0]    phase_next [`OPL_NUM_CHANNELS];
    opl_lite_pkg::sample_t chan       [`OPL_NUM_CHANNELS];       // registered samples

    // sample rate enable
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= 1'b0;
            if (div_cnt == DIV_W'(`OPL_CLK_DIV_COUNT - 1)) begin
                div_cnt     <= '0;
                sample_tick <= 1'b1;                             // one clk wide
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `OPL_NUM_CHANNELS; i++)
            phase_next[i] = phase[i] + PHASE_W'(ctrl.fnum[i]);   // one step ahead
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            channel_valid <= 1'b0;
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
                phase[i] <= '0;
                chan[i]  <= '0;
            end
        end else begin
            channel_valid <= sample_tick;
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
                if (!ctrl.kon[i]) begin
                    phase[i] <= '0;                              // key off parks the phase
                    if (sample_tick)
                        chan[i] <= '0;                           // silent
                end else if (sample_tick) begin
                    phase[i] <= phase_next[i];
                    chan[i]  <= phase_next[i][PHASE_W-1] ? -AMP : AMP;  // top bit picks polarity
                end
            end
        end
    end

    assign channel_a = chan[0];
    assign channel_b = chan[1];
    assign channel_c = chan[2];
    assign channel_d = chan[3];

    a_valid_after_tick: assert property (@(posedge clk) disable iff (reset)
        channel_valid == $past(sample_tick) && !(channel_valid && sample_tick));

endmodule

//--- opl_host_regs.sv
/*
 * opl lite host register block
 * index latch, indexed register writes, field decode and status readback
 */
`include "opl_lite_macros.svh"

module opl_host_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cs_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic [1:0]              address,
    input  opl_lite_pkg::reg_data_t din,
    output opl_lite_pkg::reg_data_t dout,
    input  opl_lite_pkg::status_t   status,
    opl_ctrl_if.regs                ctrl
);

    opl_lite_pkg::reg_index_t index;                             // selected register
    logic wr;
    logic rd;
    logic wr_data;                                               // data write at address 1

    assign wr      = !cs_n && !wr_n;
    assign rd      = !cs_n && !rd_n;
    assign wr_data = wr && (address == 2'd1);

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            index        <= '0;
            ctrl.st1     <= 1'b0;
            ctrl.st2     <= 1'b0;
            ctrl.mt1     <= 1'b0;
            ctrl.mt2     <= 1'b0;
            ctrl.irq_rst <= 1'b0;
            ctrl.kon     <= '0;
        end else begin
            ctrl.irq_rst <= 1'b0;                                // pulse by default
            if (wr && address == 2'd0)
                index <= din;                                    // address phase
            if (wr_data && index == opl_lite_pkg::REG_TIMER_CTRL) begin
                if (din[opl_lite_pkg::CTRL_IRQ_RST]) begin
                    ctrl.irq_rst <= 1'b1;                        // other bits untouched
                end else begin
                    ctrl.mt1 <= din[opl_lite_pkg::CTRL_MT1];
                    ctrl.mt2 <= din[opl_lite_pkg::CTRL_MT2];
                    ctrl.st2 <= din[opl_lite_pkg::CTRL_ST2];
                    ctrl.st1 <= din[opl_lite_pkg::CTRL_ST1];
                end
            end
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++)
                if (wr_data && index == (opl_lite_pkg::REG_KON_FNUM |
                                         opl_lite_pkg::reg_index_t'(i)))
                    ctrl.kon[i] <= din[opl_lite_pkg::KON_BIT];
        end
    end

    // presets and frequency numbers
    always_ff @(posedge clk) begin
        if (wr_data && index == opl_lite_pkg::REG_TIMER1)
            ctrl.timer1 <= din;
        if (wr_data && index == opl_lite_pkg::REG_TIMER2)
            ctrl.timer2 <= din;
        for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
            if (wr_data && index == (opl_lite_pkg::REG_FNUM_LO |
                                     opl_lite_pkg::reg_index_t'(i)))
                ctrl.fnum[i][7:0] <= din;                        // low byte
            if (wr_data && index == (opl_lite_pkg::REG_KON_FNUM |
                                     opl_lite_pkg::reg_index_t'(i)))
                ctrl.fnum[i][9:8] <= din[1:0];                   // high bits
        end
    end

    // status readback one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset)
            dout <= '0;
        else if (rd)
            dout <= (address == 2'd0) ? status : '0;             // other addresses read 0
    end

    a_irq_rst_pulse: assert property (@(posedge clk) disable iff (reset)
        ctrl.irq_rst |=> !ctrl.irq_rst);

endmodule

//--- opl_ctrl_if.sv
/*
 * opl lite control bundle
 * decoded register fields from the register block to the timers and the tone channels
 */
`include "opl_lite_macros.svh"

interface opl_ctrl_if;

    opl_lite_pkg::timer_t timer1;                                // presets
    opl_lite_pkg::timer_t timer2;
    logic st1;                                                   // timer starts
    logic st2;
    logic mt1;                                                   // flag masks
    logic mt2;
    logic irq_rst;                                               // one cycle, clears flags

    opl_lite_pkg::fnum_t fnum [`OPL_NUM_CHANNELS];               // per channel pitch
    logic [`OPL_NUM_CHANNELS-1:0] kon;                           // per channel key on

    modport regs (
        output timer1, timer2, st1, st2, mt1, mt2, irq_rst,
        output fnum, kon
    );

    modport timers (
        input timer1, timer2, st1, st2, mt1, mt2, irq_rst
    );

    modport tone (
        input fnum, kon
    );

endinterface

//--- opl_lite_pkg.sv
/*
 * opl lite shared types
 * register index and data bytes, sample and mix words, status byte and register map
 */
`include "opl_lite_macros.svh"

package opl_lite_pkg;

    typedef logic [7:0] reg_index_t;                             // indexed register address
    typedef logic [7:0] reg_data_t;                              // host data byte
    typedef logic [9:0] fnum_t;                                  // frequency number
    typedef logic [7:0] timer_t;                                 // timer preset / count
    typedef logic signed [`OPL_SAMPLE_WIDTH-1:0] sample_t;       // one channel
    typedef logic signed [`OPL_SAMPLE_WIDTH:0] mix_t;            // sum of two channels

    // status byte as read from address 0
    typedef struct packed {
        logic       irq;                                         // either flag set
        logic       ft1;                                         // timer 1 overflow
        logic       ft2;                                         // timer 2 overflow
        logic [4:0] zero;                                        // always read as 0
    } status_t;

    // register map
    localparam reg_index_t REG_TIMER1     = 8'h02;               // timer 1 preset
    localparam reg_index_t REG_TIMER2     = 8'h03;               // timer 2 preset
    localparam reg_index_t REG_TIMER_CTRL = 8'h04;               // irq_rst, masks, starts
    localparam reg_index_t REG_FNUM_LO    = 8'hA0;               // 0xa0..0xa3, fnum[7:0]
    localparam reg_index_t REG_KON_FNUM   = 8'hB0;               // 0xb0..0xb3, kon + fnum[9:8]

    // timer control bit positions
    localparam int CTRL_IRQ_RST = 7;
    localparam int CTRL_MT1     = 6;
    localparam int CTRL_MT2     = 5;
    localparam int CTRL_ST2     = 1;
    localparam int CTRL_ST1     = 0;

    localparam int KON_BIT = 5;                                  // in the 0xb0 group

endpackage

//--- opl_lite_macros.svh
/*
 * opl lite build constants
 * divider counts, channel count, datapath widths and tone level
 */
`ifndef OPL_LITE_MACROS_SVH
`define OPL_LITE_MACROS_SVH

// clock and sample rate division
`define OPL_CLK_DIV_COUNT 8        // clk cycles per sample tick
`define OPL_TIMER1_DIV    4        // sample ticks per timer 1 step
`define OPL_TIMER2_DIV    16       // sample ticks per timer 2 step

// channel datapath
`define OPL_NUM_CHANNELS  4
`define OPL_PHASE_WIDTH   16       // phase accumulator bits
`define OPL_SAMPLE_WIDTH  16       // signed channel sample bits
`define OPL_AMPLITUDE     4096     // square wave level, well inside the sample range

`endif
